//--- tetris_pkg.sv
package tetris_pkg;

    // ========================================
    // Screen and cell geometry
    // ========================================
    localparam int scr_w       = 1280;
    localparam int scr_h       = 800;

    localparam int block_size  = 32;
    localparam int block_bits  = 5;

    localparam int field_cols  = 10;
    localparam int hidden_rows = 2;
    localparam int vis_rows    = 20;
    localparam int field_rows  = hidden_rows + vis_rows;

    // Playfield centred on the screen
    localparam int grid_w      = field_cols * block_size;
    localparam int grid_h      = vis_rows * block_size;
    localparam int grid_x0     = (scr_w - grid_w) / 2;
    localparam int grid_y0     = (scr_h - grid_h) / 2;
    localparam int border_w    = 4;

    // Next-piece box to the right of the playfield
    localparam int next_x0     = grid_x0 + grid_w + 50;
    localparam int next_y0     = grid_y0;
    localparam int box_size    = 150;
    localparam int header_h    = 20;
    localparam int preview_dx  = 20;
    localparam int preview_dy  = 40;

    // ========================================
    // Types
    // ========================================
    typedef logic [10:0] px_x_t;
    typedef logic [9:0]  px_y_t;
    typedef logic [11:0] rgb_t;
    typedef logic [2:0]  cell_t;

    // Codes 0..6 are I, J, L, O, S, T, Z
    localparam cell_t cell_empty = 3'd7;

    // ========================================
    // Piece shapes and colors
    // ========================================
    // Rotation 0 masks, bit index is row*4 + col
    localparam logic [15:0] shape_rom [7] = '{
        16'h00F0,   // I
        16'h0071,   // J
        16'h0074,   // L
        16'h0066,   // O
        16'h0036,   // S
        16'h0072,   // T
        16'h0063    // Z
    };

    // Index 0 is background, piece code + 1 otherwise
    localparam rgb_t color_rom [8] = '{
        12'h000,
        12'hF00,
        12'h0F0,
        12'h00F,
        12'hFF0,
        12'hF0F,
        12'h0FF,
        12'hFA0
    };

    localparam rgb_t grey_over  = 12'h666;
    localparam rgb_t grey_ghost = 12'h444;

    // Sprite intensity meaning full brightness
    localparam logic [3:0] shade_full = 4'hF;

endpackage

//--- screen_locator.sv
module screen_locator (
    input  logic                clk,
    input  logic                arst_n,
    input  tetris_pkg::px_x_t   curr_x,
    input  tetris_pkg::px_y_t   curr_y,
    input  logic                active_area,
    input  logic                hsync_in,
    input  logic                vsync_in,
    output logic                s1_active,
    output logic                s1_hsync,
    output logic                s1_vsync,
    output logic                in_grid,
    output logic                in_border,
    output logic                in_next,
    output logic                in_header,
    output logic [4:0]          grid_row,
    output logic [3:0]          grid_col,
    output logic [4:0]          pix_x,
    output logic [4:0]          pix_y,
    output logic [1:0]          next_row,
    output logic [1:0]          next_col,
    output logic [4:0]          next_pix_x,
    output logic [4:0]          next_pix_y,
    output logic                preview_ok
);
    import tetris_pkg::*;

    px_x_t rel_gx, rel_nx, prev_x;
    px_y_t rel_gy, rel_ny, prev_y;
    logic  grid_c, frame_c, next_c, preview_c;

    // ========================================
    // Region tests on the raw raster position
    // ========================================
    assign rel_gx = curr_x - px_x_t'(grid_x0);
    assign rel_gy = curr_y - px_y_t'(grid_y0);
    assign rel_nx = curr_x - px_x_t'(next_x0);
    assign rel_ny = curr_y - px_y_t'(next_y0);
    assign prev_x = rel_nx - px_x_t'(preview_dx);
    assign prev_y = rel_ny - px_y_t'(preview_dy);

    assign grid_c = curr_x >= grid_x0 && curr_x < grid_x0 + grid_w &&
                    curr_y >= grid_y0 && curr_y < grid_y0 + grid_h;

    // Playfield grown by the frame on every side
    assign frame_c = curr_x >= grid_x0 - border_w && curr_x < grid_x0 + grid_w + border_w &&
                     curr_y >= grid_y0 - border_w && curr_y < grid_y0 + grid_h + border_w;

    assign next_c = curr_x >= next_x0 && curr_x < next_x0 + box_size &&
                    curr_y >= next_y0 && curr_y < next_y0 + box_size;

    // 4x4 block area of the preview piece
    assign preview_c = rel_nx >= preview_dx && prev_x < 4 * block_size &&
                       rel_ny >= preview_dy && prev_y < 4 * block_size;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_active  <= 1'b0;
            s1_hsync   <= 1'b0;
            s1_vsync   <= 1'b0;
            in_grid    <= 1'b0;
            in_border  <= 1'b0;
            in_next    <= 1'b0;
            in_header  <= 1'b0;
            preview_ok <= 1'b0;
        end else begin
            s1_active  <= active_area;
            s1_hsync   <= hsync_in;
            s1_vsync   <= vsync_in;
            in_grid    <= grid_c;
            in_border  <= frame_c && !grid_c;
            in_next    <= next_c;
            in_header  <= next_c && rel_ny < header_h;
            preview_ok <= next_c && preview_c;
        end
    end

    // Cell index and pixel offset splits
    always_ff @(posedge clk) begin
        grid_row   <= rel_gy[block_bits +: 5];
        grid_col   <= rel_gx[block_bits +: 4];
        pix_x      <= rel_gx[block_bits-1:0];
        pix_y      <= rel_gy[block_bits-1:0];
        next_row   <= prev_y[block_bits +: 2];
        next_col   <= prev_x[block_bits +: 2];
        next_pix_x <= prev_x[block_bits-1:0];
        next_pix_y <= prev_y[block_bits-1:0];
    end

    a_regions_disjoint: assert property (
        @(posedge clk) disable iff (!arst_n) $onehot0({in_grid, in_border, in_next})
    );

endmodule

//--- piece_mask.sv
module piece_mask (
    input  tetris_pkg::cell_t   piece,
    input  logic [1:0]          rot,
    input  logic signed [5:0]   origin_row,
    input  logic signed [4:0]   origin_col,
    input  logic [5:0]          row,
    input  logic [4:0]          col,
    output logic                hit
);
    import tetris_pkg::*;

    logic signed [6:0] d_row;
    logic signed [5:0] d_col;
    logic              in_box;
    logic [1:0]        r, c;
    logic [1:0]        src_r, src_c;

    // Offset of the cell from the piece origin
    assign d_row  = $signed({1'b0, row}) - origin_row;
    assign d_col  = $signed({1'b0, col}) - origin_col;
    assign in_box = d_row >= 0 && d_row < 4 && d_col >= 0 && d_col < 4;
    assign r      = d_row[1:0];
    assign c      = d_col[1:0];

    // Undo the clockwise turns to find the rotation-0 cell
    always_comb begin
        case (rot)
            2'd0: begin
                src_r = r;
                src_c = c;
            end
            2'd1: begin
                src_r = ~c;
                src_c = r;
            end
            2'd2: begin
                src_r = ~r;
                src_c = ~c;
            end
            default: begin
                src_r = c;
                src_c = ~r;
            end
        endcase
    end

    always_comb begin
        hit = 1'b0;
        if (in_box && piece != cell_empty)
            hit = shape_rom[piece][{src_r, src_c}];
    end

endmodule

//--- cell_resolver.sv
module cell_resolver (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                game_over,
    input  tetris_pkg::cell_t   piece_type,
    input  logic [1:0]          piece_rot,
    input  logic signed [4:0]   piece_col,
    input  logic signed [5:0]   ghost_row,
    input  tetris_pkg::cell_t   next_type,
    input  tetris_pkg::cell_t   field_cell,
    input  logic                s1_active,
    input  logic                s1_hsync,
    input  logic                s1_vsync,
    input  logic                in_grid,
    input  logic                in_border,
    input  logic                in_next,
    input  logic                in_header,
    input  logic [4:0]          grid_row,
    input  logic [3:0]          grid_col,
    input  logic [4:0]          pix_x,
    input  logic [4:0]          pix_y,
    input  logic [1:0]          next_row,
    input  logic [1:0]          next_col,
    input  logic [4:0]          next_pix_x,
    input  logic [4:0]          next_pix_y,
    input  logic                preview_ok,
    output logic [4:0]          field_row,
    output logic [3:0]          field_col,
    output logic [3:0]          sprite_addr_x,
    output logic [3:0]          sprite_addr_y,
    output logic                s2_active,
    output logic                s2_hsync,
    output logic                s2_vsync,
    output logic                s2_border,
    output logic                s2_grid,
    output logic                s2_header,
    output logic [3:0]          color_idx,
    output logic                is_ghost
);
    import tetris_pkg::*;

    logic       ghost_hit, next_hit;
    logic [3:0] color_d;
    logic       ghost_d;
    logic [3:0] addr_x_d, addr_y_d;

    // Field read port, visible row offset past the hidden rows
    assign field_row = grid_row + 5'(hidden_rows);
    assign field_col = grid_col;

    piece_mask u_ghost_mask (
        .piece      (piece_type),
        .rot        (piece_rot),
        .origin_row (ghost_row),
        .origin_col (piece_col),
        .row        ({1'b0, field_row}),
        .col        ({1'b0, grid_col}),
        .hit        (ghost_hit)
    );

    // Preview always sits at the box origin in rotation 0
    piece_mask u_next_mask (
        .piece      (next_type),
        .rot        (2'd0),
        .origin_row (6'sd0),
        .origin_col (5'sd0),
        .row        ({4'd0, next_row}),
        .col        ({3'd0, next_col}),
        .hit        (next_hit)
    );

    // ========================================
    // Cell selection
    // ========================================
    always_comb begin
        color_d  = '0;
        ghost_d  = 1'b0;
        addr_x_d = '0;
        addr_y_d = '0;
        if (in_grid) begin
            if (field_cell != cell_empty) begin
                color_d  = 4'(field_cell) + 4'd1;
                addr_x_d = pix_x[4:1];
                addr_y_d = pix_y[4:1];
            end else if (ghost_hit && !game_over) begin
                ghost_d  = 1'b1;
                addr_x_d = pix_x[4:1];
                addr_y_d = pix_y[4:1];
            end
        end else if (in_next && !in_header && preview_ok && next_hit) begin
            color_d  = 4'(next_type) + 4'd1;
            addr_x_d = next_pix_x[4:1];
            addr_y_d = next_pix_y[4:1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s2_active     <= 1'b0;
            s2_hsync      <= 1'b0;
            s2_vsync      <= 1'b0;
            s2_border     <= 1'b0;
            s2_grid       <= 1'b0;
            s2_header     <= 1'b0;
            color_idx     <= '0;
            is_ghost      <= 1'b0;
            sprite_addr_x <= '0;
            sprite_addr_y <= '0;
        end else begin
            s2_active     <= s1_active;
            s2_hsync      <= s1_hsync;
            s2_vsync      <= s1_vsync;
            s2_border     <= in_border;
            s2_grid       <= in_grid;
            s2_header     <= in_header;
            color_idx     <= color_d;
            is_ghost      <= ghost_d;
            sprite_addr_x <= addr_x_d;
            sprite_addr_y <= addr_y_d;
        end
    end

    a_ghost_vs_color: assert property (
        @(posedge clk) disable iff (!arst_n) !(is_ghost && color_idx != '0)
    );

endmodule

//--- pixel_shader.sv
module pixel_shader (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        game_over,
    input  logic [11:0] sprite_pixel,
    input  logic        s2_active,
    input  logic        s2_hsync,
    input  logic        s2_vsync,
    input  logic        s2_border,
    input  logic        s2_grid,
    input  logic        s2_header,
    input  logic [3:0]  color_idx,
    input  logic        is_ghost,
    output logic [3:0]  vga_r,
    output logic [3:0]  vga_g,
    output logic [3:0]  vga_b,
    output logic        hsync_out,
    output logic        vsync_out
);
    import tetris_pkg::*;

    rgb_t base;
    rgb_t rgb_d;
    logic shade_en;

    // ========================================
    // Region priority
    // ========================================
    always_comb begin
        base     = '0;
        shade_en = 1'b0;
        if (s2_active) begin
            if (s2_border) begin
                base = '1;
            end else if (s2_grid && color_idx != '0) begin
                base     = game_over ? grey_over : color_rom[color_idx[2:0]];
                shade_en = 1'b1;
            end else if (is_ghost) begin
                base     = grey_ghost;
                shade_en = 1'b1;
            end else if (s2_header) begin
                base = '1;
            end else if (color_idx != '0) begin
                // Preview block in the next box
                base     = color_rom[color_idx[2:0]];
                shade_en = 1'b1;
            end
        end
    end

    // Halve every channel where the sprite is dimmed
    assign rgb_d = (shade_en && sprite_pixel[7:4] != shade_full) ?
                   ((base >> 1) & 12'h777) : base;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
            hsync_out <= 1'b0;
            vsync_out <= 1'b0;
        end else begin
            vga_r     <= rgb_d[11:8];
            vga_g     <= rgb_d[7:4];
            vga_b     <= rgb_d[3:0];
            hsync_out <= s2_hsync;
            vsync_out <= s2_vsync;
        end
    end

    a_blank_inactive: assert property (
        @(posedge clk) disable iff (!arst_n)
        !s2_active |=> {vga_r, vga_g, vga_b} == '0
    );

endmodule

//--- tetris_renderer.sv
module tetris_renderer (
    input  logic                clk,
    input  logic                arst_n,
    input  tetris_pkg::px_x_t   curr_x,
    input  tetris_pkg::px_y_t   curr_y,
    input  logic                active_area,
    input  logic                hsync_in,
    input  logic                vsync_in,
    input  logic                game_over,
    input  tetris_pkg::cell_t   piece_type,
    input  logic [1:0]          piece_rot,
    input  logic signed [4:0]   piece_col,
    input  logic signed [5:0]   ghost_row,
    input  tetris_pkg::cell_t   next_type,
    output logic [4:0]          field_row,
    output logic [3:0]          field_col,
    input  tetris_pkg::cell_t   field_cell,
    output logic [3:0]          sprite_addr_x,
    output logic [3:0]          sprite_addr_y,
    input  logic [11:0]         sprite_pixel,
    output logic [3:0]          vga_r,
    output logic [3:0]          vga_g,
    output logic [3:0]          vga_b,
    output logic                hsync_out,
    output logic                vsync_out
);

    // Stage 1 to stage 2
    logic       s1_active, s1_hsync, s1_vsync;
    logic       in_grid, in_border, in_next, in_header, preview_ok;
    logic [4:0] grid_row, pix_x, pix_y, next_pix_x, next_pix_y;
    logic [3:0] grid_col;
    logic [1:0] next_row, next_col;

    // Stage 2 to stage 3
    logic       s2_active, s2_hsync, s2_vsync;
    logic       s2_border, s2_grid, s2_header, is_ghost;
    logic [3:0] color_idx;

    screen_locator u_locator (
        .clk, .arst_n,
        .curr_x, .curr_y, .active_area, .hsync_in, .vsync_in,
        .s1_active, .s1_hsync, .s1_vsync,
        .in_grid, .in_border, .in_next, .in_header,
        .grid_row, .grid_col, .pix_x, .pix_y,
        .next_row, .next_col, .next_pix_x, .next_pix_y,
        .preview_ok
    );

    cell_resolver u_resolver (
        .clk, .arst_n, .game_over,
        .piece_type, .piece_rot, .piece_col, .ghost_row, .next_type,
        .field_cell,
        .s1_active, .s1_hsync, .s1_vsync,
        .in_grid, .in_border, .in_next, .in_header,
        .grid_row, .grid_col, .pix_x, .pix_y,
        .next_row, .next_col, .next_pix_x, .next_pix_y,
        .preview_ok,
        .field_row, .field_col, .sprite_addr_x, .sprite_addr_y,
        .s2_active, .s2_hsync, .s2_vsync,
        .s2_border, .s2_grid, .s2_header,
        .color_idx, .is_ghost
    );

    pixel_shader u_shader (
        .clk, .arst_n, .game_over, .sprite_pixel,
        .s2_active, .s2_hsync, .s2_vsync,
        .s2_border, .s2_grid, .s2_header,
        .color_idx, .is_ghost,
        .vga_r, .vga_g, .vga_b, .hsync_out, .vsync_out
    );

endmodule

//--- tb_scene_model.svh
cell_t field_model [32][16];

// ========================================
// Field and sprite memories
// ========================================
initial begin : fill_field
    for (int r = 0; r < 32; r++) begin
        for (int c = 0; c < 16; c++) begin
            field_model[r][c] = cell_empty;
        end
    end
    // Bottom visible row holds one cell of each code
    for (int c = 0; c < 7; c++) begin
        field_model[field_rows - 1][c] = cell_t'(c);
    end
end

// Intensity in bits 7..4, dimmed only in the leftmost sprite column
function automatic logic [11:0] sprite_word(input logic [3:0] addr_x);
    if (addr_x == 4'd0) begin
        return 12'h080;
    end
    return {4'h0, shade_full, 4'h0};
endfunction

// ========================================
// Reference pixel
// ========================================
function automatic logic [15:0] turn_cw(input logic [15:0] mask);
    logic [15:0] turned;
    turned = '0;
    for (int r = 0; r < 4; r++) begin
        for (int c = 0; c < 4; c++) begin
            turned[r * 4 + c] = mask[(3 - c) * 4 + r];
        end
    end
    return turned;
endfunction

function automatic bit piece_covers(input int piece, input int rot, input int dr, input int dc);
    logic [15:0] mask;
    if (dr < 0 || dr > 3 || dc < 0 || dc > 3) begin
        return 1'b0;
    end
    mask = shape_rom[piece];
    for (int k = 0; k < rot; k++) begin
        mask = turn_cw(mask);
    end
    return mask[dr * 4 + dc];
endfunction

// Halve each channel when the sprite under this offset is dimmed
function automatic rgb_t shade_pixel(input rgb_t base, input int offset);
    logic [11:0] word;
    word = sprite_word(4'(offset / 2));
    if (word[7:4] == shade_full) begin
        return base;
    end
    return {base[11:8] >> 1, base[7:4] >> 1, base[3:0] >> 1};
endfunction

function automatic rgb_t expected_pixel(input int x, input int y, input bit act, input bit go,
                                        input int ptype, input int prot, input int pcol,
                                        input int grow, input int ntype);
    int    col, frow, ox, px, py;
    bit    in_grid, in_frame, in_next;
    cell_t code;
    if (!act) begin
        return 12'h000;
    end
    in_grid  = x >= grid_x0 && x < grid_x0 + grid_w && y >= grid_y0 && y < grid_y0 + grid_h;
    in_frame = x >= grid_x0 - border_w && x < grid_x0 + grid_w + border_w &&
               y >= grid_y0 - border_w && y < grid_y0 + grid_h + border_w;
    in_next  = x >= next_x0 && x < next_x0 + box_size && y >= next_y0 && y < next_y0 + box_size;
    if (in_frame && !in_grid) begin
        return 12'hFFF;
    end
    if (in_grid) begin
        col  = (x - grid_x0) / block_size;
        frow = (y - grid_y0) / block_size + hidden_rows;
        ox   = (x - grid_x0) % block_size;
        code = field_model[frow][col];
        if (code != cell_empty) begin
            return shade_pixel(go ? grey_over : color_rom[code + 1], ox);
        end
        if (!go && piece_covers(ptype, prot, frow - grow, col - pcol)) begin
            return shade_pixel(grey_ghost, ox);
        end
        return 12'h000;
    end
    if (in_next) begin
        if (y < next_y0 + header_h) begin
            return 12'hFFF;
        end
        px = x - next_x0 - preview_dx;
        py = y - next_y0 - preview_dy;
        if (px >= 0 && px < 4 * block_size && py >= 0 && py < 4 * block_size &&
            piece_covers(ntype, 0, py / block_size, px / block_size)) begin
            return shade_pixel(color_rom[ntype + 1], px % block_size);
        end
    end
    return 12'h000;
endfunction

//--- tb_tetris_renderer.sv
module tb_tetris_renderer;
    timeunit 1ns;
    timeprecision 100ps;

    import tetris_pkg::*;

    localparam int reset_cycles = 3;
    localparam int scan_count   = 400;

    typedef struct packed {
        logic [10:0]       x;
        logic [9:0]        y;
        logic              act;
        logic              hs;
        logic              vs;
        logic              go;
        logic [2:0]        ptype;
        logic [1:0]        prot;
        logic signed [4:0] pcol;
        logic signed [5:0] grow;
        logic [2:0]        ntype;
        logic [11:0]       rgb;
    } entry_t;

    logic              clk;
    logic              arst_n;
    px_x_t             curr_x;
    px_y_t             curr_y;
    logic              active_area, hsync_in, vsync_in;
    logic              game_over;
    cell_t             piece_type, next_type, field_cell;
    logic [1:0]        piece_rot;
    logic signed [4:0] piece_col;
    logic signed [5:0] ghost_row;
    logic [4:0]        field_row;
    logic [3:0]        field_col, sprite_addr_x, sprite_addr_y;
    logic [11:0]       sprite_pixel;
    logic [3:0]        vga_r, vga_g, vga_b;
    logic              hsync_out, vsync_out;
    logic [3:0]        sprite_y_q;

    entry_t      stim_table [$];
    logic [17:0] expect_q [$];
    string       tag_q [$];
    integer      seed;
    int          cycle_cnt;
    int          cycle_limit;

    `include "tb_scene_model.svh"

    tetris_renderer i_dut (.*);

    // Memories answer in the same cycle
    always_comb field_cell = field_model[field_row][field_col];
    assign sprite_pixel = sprite_word(sprite_addr_x);

    // Sprite row address lined up with the RGB output it shades
    always @(posedge clk) begin
        sprite_y_q <= sprite_addr_y;
    end

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ========================================
    // Checking
    // ========================================
    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic compare_front();
        logic [17:0] want;
        string       tag;
        want = expect_q.pop_front();
        tag  = tag_q.pop_front();
        check_value({vga_r, vga_g, vga_b, hsync_out, vsync_out, sprite_y_q}, want, tag);
    endtask

    // Sprite row of a shaded cell pixel, zero where nothing is shaded
    function automatic logic [3:0] expected_sprite_row(input int x, input int y, input bit go,
                                                       input int ptype, input int prot,
                                                       input int pcol, input int grow,
                                                       input int ntype);
        rgb_t lit;
        lit = expected_pixel(x, y, 1'b1, go, ptype, prot, pcol, grow, ntype);
        if (lit == 12'h000 || lit == 12'hFFF) begin
            return 4'd0;
        end
        if (x < next_x0) begin
            return 4'(((y - grid_y0) % block_size) / 2);
        end
        return 4'(((y - next_y0 - preview_dy) % block_size) / 2);
    endfunction

    // One pixel per clock, its result three edges later
    task automatic issue_pixel(input int x, input int y, input bit act, input bit hs,
                               input bit vs, input bit go, input int ptype, input int prot,
                               input int pcol, input int grow, input int ntype,
                               input rgb_t exp_rgb);
        @(posedge clk);
        curr_x      <= px_x_t'(x);
        curr_y      <= px_y_t'(y);
        active_area <= act;
        hsync_in    <= hs;
        vsync_in    <= vs;
        game_over   <= go;
        piece_type  <= cell_t'(ptype);
        piece_rot   <= 2'(prot);
        piece_col   <= 5'(pcol);
        ghost_row   <= 6'(grow);
        next_type   <= cell_t'(ntype);
        expect_q.push_back({exp_rgb, hs, vs,
                            expected_sprite_row(x, y, go, ptype, prot, pcol, grow, ntype)});
        tag_q.push_back($sformatf("pixel x=%0d y=%0d active=%0b", x, y, act));
        @(negedge clk);
        if (expect_q.size() > 3) begin
            compare_front();
        end
    endtask

    task automatic apply_entry(input entry_t e);
        if ({game_over, piece_type, piece_rot, piece_col, ghost_row, next_type} !=
            {e.go, e.ptype, e.prot, e.pcol, e.grow, e.ntype}) begin
            // Two blank pixels let the old game state leave stages 2 and 3
            repeat (2) begin
                issue_pixel(0, 0, 1'b0, 1'b0, 1'b0, game_over, piece_type, piece_rot,
                            piece_col, ghost_row, next_type, 12'h000);
            end
        end
        issue_pixel(e.x, e.y, e.act, e.hs, e.vs, e.go, e.ptype, e.prot,
                    e.pcol, e.grow, e.ntype, e.rgb);
    endtask

    task automatic add_entry(input int x, input int y, input bit act, input bit hs,
                             input bit vs, input bit go, input int ptype, input int prot,
                             input int pcol, input int grow, input int ntype, input rgb_t rgb);
        entry_t e;
        e = '{px_x_t'(x), px_y_t'(y), act, hs, vs, go, 3'(ptype), 2'(prot),
              5'(pcol), 6'(grow), 3'(ntype), rgb};
        stim_table.push_back(e);
    endtask

    // ========================================
    // Stimulus table
    // ========================================
    task automatic build_table();
        // Frame, far background, blanking
        add_entry( 478, 300, 1, 0, 0, 0, 5, 0, 3,  8, 5, 12'hFFF);
        add_entry( 477,  77, 1, 0, 0, 0, 5, 0, 3,  8, 5, 12'hFFF);
        add_entry( 100, 100, 1, 1, 1, 0, 5, 0, 3,  8, 5, 12'h000);
        add_entry( 478, 300, 0, 1, 0, 0, 5, 0, 3,  8, 5, 12'h000);
        add_entry(1200, 700, 0, 0, 1, 0, 5, 0, 3,  8, 5, 12'h000);
        // Placed cells in the bottom row
        add_entry( 490, 700, 1, 0, 0, 0, 5, 0, 3,  8, 5, 12'hF00);
        add_entry( 522, 700, 1, 1, 0, 0, 5, 0, 3,  8, 5, 12'h0F0);
        add_entry( 554, 700, 1, 0, 0, 0, 5, 0, 3,  8, 5, 12'h00F);
        add_entry( 586, 700, 1, 0, 1, 0, 5, 0, 3,  8, 5, 12'hFF0);
        add_entry( 618, 700, 1, 0, 0, 0, 5, 0, 3,  8, 5, 12'hF0F);
        add_entry( 650, 700, 1, 0, 0, 0, 5, 0, 3,  8, 5, 12'h0FF);
        add_entry( 682, 700, 1, 0, 0, 0, 5, 0, 3,  8, 5, 12'hFA0);
        add_entry( 480, 700, 1, 0, 0, 0, 5, 0, 3,  8, 5, 12'h700);
        add_entry( 513, 700, 1, 0, 0, 0, 5, 0, 3,  8, 5, 12'h070);
        add_entry( 672, 700, 1, 0, 0, 0, 5, 0, 3,  8, 5, 12'h750);
        add_entry( 714, 700, 1, 0, 0, 0, 5, 0, 3,  8, 5, 12'h000);
        // T ghost at field row 8, column 3, all four rotations
        add_entry( 624, 288, 1, 0, 0, 0, 5, 0, 3,  8, 5, 12'h444);
        add_entry( 592, 288, 1, 0, 0, 0, 5, 0, 3,  8, 5, 12'h000);
        add_entry( 656, 320, 1, 0, 0, 0, 5, 0, 3,  8, 5, 12'h444);
        add_entry( 900,  90, 1, 0, 0, 0, 5, 0, 3,  8, 5, 12'hFFF);
        add_entry( 855, 110, 1, 0, 0, 0, 5, 0, 3,  8, 5, 12'h000);
        add_entry( 950, 168, 1, 0, 0, 0, 5, 0, 3,  8, 5, 12'h0FF);
        add_entry( 886, 136, 1, 0, 0, 0, 5, 0, 3,  8, 5, 12'h000);
        add_entry( 688, 320, 1, 0, 0, 0, 5, 1, 3,  8, 5, 12'h444);
        add_entry( 624, 288, 1, 0, 0, 0, 5, 1, 3,  8, 5, 12'h000);
        add_entry( 656, 384, 1, 0, 0, 0, 5, 2, 3,  8, 5, 12'h444);
        add_entry( 624, 288, 1, 0, 0, 0, 5, 2, 3,  8, 5, 12'h000);
        add_entry( 592, 352, 1, 0, 0, 0, 5, 3, 3,  8, 5, 12'h444);
        add_entry( 656, 320, 1, 0, 0, 0, 5, 3, 3,  8, 5, 12'h000);
        add_entry( 576, 352, 1, 0, 0, 0, 5, 3, 3,  8, 5, 12'h222);
        // Preview of every next piece
        add_entry( 886, 168, 1, 0, 0, 0, 5, 3, 3,  8, 0, 12'hF00);
        add_entry( 886, 136, 1, 0, 0, 0, 5, 3, 3,  8, 0, 12'h000);
        add_entry( 886, 136, 1, 0, 0, 0, 5, 3, 3,  8, 1, 12'h0F0);
        add_entry( 918, 136, 1, 0, 0, 0, 5, 3, 3,  8, 1, 12'h000);
        add_entry( 950, 136, 1, 0, 0, 0, 5, 3, 3,  8, 2, 12'h00F);
        add_entry( 886, 136, 1, 0, 0, 0, 5, 3, 3,  8, 2, 12'h000);
        add_entry( 918, 136, 1, 0, 0, 0, 5, 3, 3,  8, 3, 12'hFF0);
        add_entry( 886, 136, 1, 0, 0, 0, 5, 3, 3,  8, 3, 12'h000);
        add_entry( 886, 168, 1, 0, 0, 0, 5, 3, 3,  8, 4, 12'hF0F);
        add_entry( 886, 136, 1, 0, 0, 0, 5, 3, 3,  8, 4, 12'h000);
        add_entry( 886, 136, 1, 0, 0, 0, 5, 3, 3,  8, 6, 12'hFA0);
        add_entry( 886, 168, 1, 0, 0, 0, 5, 3, 3,  8, 6, 12'h000);
        add_entry( 870, 136, 1, 0, 0, 0, 5, 3, 3,  8, 6, 12'h750);
        // O ghost over the placed row, then game over
        add_entry( 522, 700, 1, 0, 0, 0, 3, 0, 0, 20, 6, 12'h0F0);
        add_entry( 522, 670, 1, 0, 0, 0, 3, 0, 0, 20, 6, 12'h444);
        add_entry( 490, 670, 1, 0, 0, 0, 3, 0, 0, 20, 6, 12'h000);
        add_entry( 522, 700, 1, 0, 0, 1, 3, 0, 0, 20, 6, 12'h666);
        add_entry( 522, 670, 1, 0, 0, 1, 3, 0, 0, 20, 6, 12'h000);
        add_entry( 481, 700, 1, 0, 0, 1, 3, 0, 0, 20, 6, 12'h333);
        add_entry( 478, 300, 1, 1, 1, 1, 3, 0, 0, 20, 6, 12'hFFF);
    endtask

    // Mostly around the playfield and next box, every tenth anywhere on screen
    task automatic random_scan();
        int     x, y;
        bit     act, hs, vs;
        entry_t e;
        for (int i = 0; i < scan_count; i++) begin
            if (i % 10 == 0) begin
                x = {$random(seed)} % scr_w;
                y = {$random(seed)} % scr_h;
            end else begin
                x = 460 + {$random(seed)} % 560;
                y = 60 + {$random(seed)} % 690;
            end
            act = ({$random(seed)} % 8) != 0;
            hs  = ({$random(seed)} % 2) != 0;
            vs  = ({$random(seed)} % 2) != 0;
            // L ghost at rotation 1, hanging off the left wall
            e = '{px_x_t'(x), px_y_t'(y), act, hs, vs, 1'b0, 3'd2, 2'd1, -5'sd1, 6'sd14,
                  3'd4, expected_pixel(x, y, act, 1'b0, 2, 1, -1, 14, 4)};
            apply_entry(e);
        end
    endtask

    task automatic drain_pipeline();
        repeat (3) begin
            @(posedge clk);
            @(negedge clk);
            compare_front();
        end
    endtask

    // ========================================
    // Run control
    // ========================================
    initial begin : watchdog
        cycle_cnt = 0;
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run was still going after %0d clock cycles", cycle_limit);
        $display("TEST FAILED");
        $fatal(1);
    end

    initial begin
        seed        = 32'h2d7;
        arst_n      = 1'b0;
        curr_x      = '0;
        curr_y      = '0;
        active_area = 1'b0;
        hsync_in    = 1'b0;
        vsync_in    = 1'b0;
        game_over   = 1'b0;
        piece_type  = '0;
        piece_rot   = '0;
        piece_col   = '0;
        ghost_row   = '0;
        next_type   = '0;
        build_table();
        // Every entry may bring two blank pixels
        cycle_limit = 3 * stim_table.size() + scan_count + reset_cycles + 20;

        repeat (reset_cycles - 1) @(posedge clk);
        @(negedge clk);
        check_value({vga_r, vga_g, vga_b, hsync_out, vsync_out, sprite_addr_x, sprite_addr_y},
                    '0, "outputs in reset");
        @(posedge clk);
        arst_n <= 1'b1;

        foreach (stim_table[i]) begin
            apply_entry(stim_table[i]);
        end
        random_scan();
        drain_pipeline();

        $display("TEST OK");
        $finish;
    end

endmodule

//--- build.f
+incdir+.
tetris_pkg.sv
screen_locator.sv
piece_mask.sv
cell_resolver.sv
pixel_shader.sv
tetris_renderer.sv
tb_tetris_renderer.sv
